// File: build.f
+incdir+verif
rtl/r0_pkg.sv
rtl/alu16.sv
rtl/r0_flags.sv
rtl/wb_cpu_port.sv
rtl/cpu_flags_top.sv
verif/tb_cpu_flags.sv

// File: verif/tb_vectors.svh
/*
	Fixed stimulus table for the R0 flag testbench
	Rows run in order and R0 carries over from row to row
*/

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: opcode or load address, A, B or load data, expected R0, expected result
// Expected R0 hex is read with bit 0 (Z) as the MSB
localparam int n_fixed = 22;

vec_t vectors [0:n_fixed-1];

task automatic fill_table();
	// User bits set first so later rows show them held
	vectors[0] = make_load_row(r0_pkg::adr_r0_user, 16'hffff, 16'h007f, 16'h0000);
	// Signed overflow into the sign bit
	vectors[1] = make_op_row(r0_pkg::op_add, 16'h7fff, 16'h0001, 16'h607f, 16'h8000);
	// Carry out with a zero result
	vectors[2] = make_op_row(r0_pkg::op_add, 16'hffff, 16'h0001, 16'h907f, 16'h0000);
	// Borrow case, carry of a plus not b plus one is clear
	vectors[3] = make_op_row(r0_pkg::op_sub, 16'h0000, 16'h0001, 16'h407f, 16'hffff);
	vectors[4] = make_op_row(r0_pkg::op_sub, 16'h8000, 16'h0001, 16'h307f, 16'h7fff);
	vectors[5] = make_op_row(r0_pkg::op_sub, 16'h0005, 16'h0005, 16'h907f, 16'h0000);
	// Logic ops move only Z
	vectors[6] = make_op_row(r0_pkg::op_or, 16'h1200, 16'h0034, 16'h107f, 16'h1234);
	vectors[7] = make_op_row(r0_pkg::op_and, 16'hf0f0, 16'h0f0f, 16'h907f, 16'h0000);
	vectors[8] = make_op_row(r0_pkg::op_xor, 16'haaaa, 16'h5555, 16'h107f, 16'hffff);
	// Compare, equal then less then greater, result held
	vectors[9] = make_op_row(r0_pkg::op_cmp, 16'h0005, 16'h0005, 16'h147f, 16'hffff);
	vectors[10] = make_op_row(r0_pkg::op_cmp, 16'hffff, 16'h0001, 16'h187f, 16'hffff);
	vectors[11] = make_op_row(r0_pkg::op_cmp, 16'h0001, 16'h8000, 16'h127f, 16'hffff);
	// Shifts
	vectors[12] = make_op_row(r0_pkg::op_shl, 16'h8001, 16'h0000, 16'h137f, 16'h0002);
	vectors[13] = make_op_row(r0_pkg::op_shr, 16'h0001, 16'h0000, 16'h93ff, 16'h0000);
	vectors[14] = make_op_row(r0_pkg::op_shl, 16'h4000, 16'h0000, 16'h12ff, 16'h8000);
	vectors[15] = make_op_row(r0_pkg::op_shr, 16'h0002, 16'h0000, 16'h127f, 16'h0001);
	// Group loads with every bit set, then sparse patterns
	vectors[16] = make_load_row(r0_pkg::adr_r0_zmvc, 16'hffff, 16'hf27f, 16'h0001);
	vectors[17] = make_load_row(r0_pkg::adr_r0_legy, 16'ha5a5, 16'hf57f, 16'h0001);
	vectors[18] = make_load_row(r0_pkg::adr_r0_x, 16'h0080, 16'hf5ff, 16'h0001);
	vectors[19] = make_load_row(r0_pkg::adr_r0_user, 16'h0055, 16'hf5d5, 16'h0001);
	vectors[20] = make_load_row(r0_pkg::adr_r0_zmvc, 16'h5000, 16'h55d5, 16'h0001);
	vectors[21] = make_load_row(r0_pkg::adr_r0_x, 16'hff7f, 16'h5555, 16'h0001);
endtask

`endif

// File: verif/tb_cpu_flags.sv
/*
	Testbench for the R0 flag subsystem
	Runs a fixed table of operations and group loads over Wishbone, then
	random add, subtract and compare rows against a flag model
*/

`timescale 1ns/1ns

module tb_cpu_flags;

	// One table row, ld doubles as the load word for load rows
	typedef struct packed {
		logic is_load;
		logic [2:0] code;
		logic [15:0] a;
		logic [15:0] b;
		logic [0:15] ld;
		logic [0:15] exp_r0;
		logic [15:0] exp_res;
	} vec_t;

	localparam int n_rand = 12;

	logic clk0;
	logic reset4;
	r0_pkg::wb_req_t wb_in;
	r0_pkg::wb_rsp_t wb_out;

	int mismatches = 0;
	int ack_errors = 0;
	int cycles = 0;
	logic [0:15] model_r0;
	logic [15:0] model_res;
	logic [15:0] rd;
	vec_t row;

	function automatic vec_t make_op_row(input r0_pkg::alu_op_t op, input logic [15:0] a,
		input logic [15:0] b, input logic [0:15] exp_r0, input logic [15:0] exp_res);
		return {1'b0, op, a, b, 16'h0000, exp_r0, exp_res};
	endfunction

	function automatic vec_t make_load_row(input logic [2:0] adr, input logic [0:15] ld,
		input logic [0:15] exp_r0, input logic [15:0] exp_res);
		return {1'b1, adr, 16'h0000, 16'h0000, ld, exp_r0, exp_res};
	endfunction

	`include "tb_vectors.svh"

	// Room for reset plus a full row of bus accesses
	localparam int cycle_limit = 16 + 40 * (n_fixed + n_rand);

	cpu_flags_top dut0 (
		.clk0   (clk0),
		.reset4 (reset4),
		.wb_in  (wb_in),
		.wb_out (wb_out)
	);

	// 20 ns clock
	initial begin
		clk0 = 1'b0;
		forever begin
			#10 clk0 = ~clk0;
		end
	end

	// Run length guard
	always @(posedge clk0) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	// One classic cycle, request held until ack or 4 cycles pass
	task automatic bus_access(input logic we, input logic [2:0] adr, input logic [15:0] wdat,
		output logic [15:0] rdat);
		int waited;
		logic got_ack;
		waited = 0;
		got_ack = 1'b0;
		rdat = 'x;
		@(posedge clk0);
		#2;
		wb_in.cyc = 1'b1;
		wb_in.stb = 1'b1;
		wb_in.we = we;
		wb_in.adr = adr;
		wb_in.dat = wdat;
		// Ack and read data settle just after the edge
		while (!got_ack && waited < 4) begin
			@(posedge clk0);
			#1;
			waited++;
			if (wb_out.ack) begin
				got_ack = 1'b1;
				rdat = wb_out.dat;
			end
		end
		if (!got_ack) begin
			ack_errors++;
			$display("No ack from the DUT within 4 cycles for address %0d at %0t", adr, $time);
		end
		#1;
		wb_in = '0;
	endtask

	task automatic bus_write(input logic [2:0] adr, input logic [15:0] wdat);
		logic [15:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [2:0] adr, output logic [15:0] rdat);
		bus_access(1'b0, adr, 16'h0000, rdat);
	endtask

	task automatic check_word(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Flag word, bit 0 is Z
	task automatic check_r0(input string what, input logic [0:15] got,
		input logic [0:15] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s R0 read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Operands, then the opcode or the load, then the readback
	task automatic run_row(input vec_t v, input int idx);
		logic [15:0] data;
		logic [2:0] r0_adr;
		// Rotate over the four R0 read addresses
		r0_adr = {1'b1, idx[1:0]};
		bus_write(r0_pkg::adr_a, v.a);
		bus_write(r0_pkg::adr_b, v.b);
		if (v.is_load) begin
			bus_write(v.code, v.ld);
		end else begin
			bus_write(r0_pkg::adr_op, {13'd0, v.code});
		end
		// Result first, the R0 update lands one cycle after the result register
		bus_read(r0_pkg::adr_res, data);
		check_word($sformatf("row %0d result", idx), data, v.exp_res);
		bus_read(r0_adr, data);
		check_r0($sformatf("row %0d", idx), data, v.exp_r0);
	endtask

	// Random add, subtract or compare with flags from the architecture rules
	function automatic vec_t random_row();
		vec_t v;
		logic [16:0] sum;
		int unsigned pick;
		v = '0;
		v.a = $urandom;
		v.b = $urandom;
		// Equal operands now and then for E and Z
		if ($urandom % 4 == 0) begin
			v.b = v.a;
		end
		pick = $urandom % 3;
		v.exp_r0 = model_r0;
		v.exp_res = model_res;
		if (pick == 0) begin
			v.code = r0_pkg::op_add;
			sum = {1'b0, v.a} + {1'b0, v.b};
			v.exp_r0[r0_pkg::f_v] = (v.a[15] == v.b[15]) && (sum[15] != v.a[15]);
		end else if (pick == 1) begin
			v.code = r0_pkg::op_sub;
			sum = {1'b0, v.a} + {1'b0, ~v.b} + 17'd1;
			v.exp_r0[r0_pkg::f_v] = (v.a[15] != v.b[15]) && (sum[15] != v.a[15]);
		end else begin
			v.code = r0_pkg::op_cmp;
			v.exp_r0[r0_pkg::f_l] = $signed(v.a) < $signed(v.b);
			v.exp_r0[r0_pkg::f_e] = (v.a == v.b);
			v.exp_r0[r0_pkg::f_g] = $signed(v.a) > $signed(v.b);
		end
		// Z, M, C and the result only for add and subtract
		if (pick != 2) begin
			v.exp_res = sum[15:0];
			v.exp_r0[r0_pkg::f_z] = (sum[15:0] == 16'd0);
			v.exp_r0[r0_pkg::f_m] = sum[15];
			v.exp_r0[r0_pkg::f_c] = sum[16];
		end
		return v;
	endfunction

	initial begin
		void'($urandom(32'h9911));
		wb_in = '0;
		reset4 = 1'b0;
		model_r0 = '0;
		model_res = '0;
		repeat (16) @(posedge clk0);
		#2;
		reset4 = 1'b1;

		// Reset state
		bus_read(r0_pkg::adr_r0_zmvc, rd);
		check_r0("after reset", rd, 16'h0000);
		bus_read(r0_pkg::adr_a, rd);
		check_word("A after reset", rd, 16'h0000);
		bus_read(r0_pkg::adr_b, rd);
		check_word("B after reset", rd, 16'h0000);
		bus_read(r0_pkg::adr_res, rd);
		check_word("result after reset", rd, 16'h0000);

		fill_table();
		for (int i = 0; i < n_fixed; i++) begin
			run_row(vectors[i], i);
			model_r0 = vectors[i].exp_r0;
			model_res = vectors[i].exp_res;
		end

		// Random rows start from the state the table left
		for (int i = 0; i < n_rand; i++) begin
			row = random_row();
			run_row(row, n_fixed + i);
			model_r0 = row.exp_r0;
			model_res = row.exp_res;
		end

		$display("Errors: %0d mismatches, %0d missing acks", mismatches, ack_errors);
		if (mismatches == 0 && ack_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/cpu_flags_top.sv
/*
	R0 flag subsystem top level
	Wishbone port driving the ALU and the R0 flag register
*/

`timescale 1ns/1ns

module cpu_flags_top (
	input logic clk0,
	input logic reset4,
	input r0_pkg::wb_req_t wb_in,
	output r0_pkg::wb_rsp_t wb_out
);

	logic [15:0] opa;
	logic [15:0] opb;
	logic [15:0] alu_res;
	logic [0:15] r0_word;
	r0_pkg::alu_op_t alu_op;
	r0_pkg::alu_flags_t alu_flags;
	r0_pkg::r0_cmd_t r0_cmd;

	// Bus side, operands and command source
	wb_cpu_port port0 (
		.clk0   (clk0),
		.reset4 (reset4),
		.req    (wb_in),
		.r0     (r0_word),
		.res    (alu_res),
		.rsp    (wb_out),
		.a      (opa),
		.b      (opb),
		.op     (alu_op),
		.cmd    (r0_cmd)
	);

	// Sees operands and opcode with no latency
	alu16 alu0 (
		.a     (opa),
		.b     (opb),
		.op    (alu_op),
		.res   (alu_res),
		.flags (alu_flags)
	);

	// Flag register
	r0_flags flags0 (
		.clk0   (clk0),
		.reset4 (reset4),
		.cmd    (r0_cmd),
		.src    (alu_flags),
		.r0     (r0_word)
	);

endmodule

// File: rtl/wb_cpu_port.sv
/*
	Wishbone classic slave port
	Holds operands, opcode and result, turns bus writes into R0 group
	loads, runs an execute one cycle after the opcode write, returns reads
*/

`timescale 1ns/1ns

module wb_cpu_port (
	input logic clk0,
	input logic reset4,
	input r0_pkg::wb_req_t req,
	input logic [0:15] r0,
	input logic [15:0] res,
	output r0_pkg::wb_rsp_t rsp,
	output logic [15:0] a,
	output logic [15:0] b,
	output r0_pkg::alu_op_t op,
	output r0_pkg::r0_cmd_t cmd
);

	logic ack_q;
	logic acc;
	logic wr;
	logic exe_pend;
	logic [15:0] res_q;
	logic [15:0] rd_dat;
	r0_pkg::r0_cmd_t cmd_n;

	// New access seen while ack is low
	assign acc = req.cyc & req.stb & ~ack_q;
	assign wr = acc & req.we;

	// Single-cycle ack, no wait states
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= acc;
		end
	end

	// Operands, opcode latch and execute pending
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			a <= '0;
			b <= '0;
			op <= r0_pkg::op_add;
			exe_pend <= 1'b0;
		end else begin
			// Execute runs in the cycle after the opcode write
			exe_pend <= wr && (req.adr == r0_pkg::adr_op);
			if (wr) begin
				case (req.adr)
					r0_pkg::adr_a: begin
						a <= req.dat;
					end
					r0_pkg::adr_b: begin
						b <= req.dat;
					end
					r0_pkg::adr_op: begin
						op <= r0_pkg::alu_op_t'(req.dat[2:0]);
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Result register, compare leaves it alone
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			res_q <= '0;
		end else if (exe_pend && (op != r0_pkg::op_cmp)) begin
			res_q <= res;
		end
	end

	// Command decode
	always_comb begin
		cmd_n = '0;

		// Group loads from writes to addresses 4 to 7
		if (wr) begin
			case (req.adr)
				r0_pkg::adr_r0_zmvc: cmd_n.load_zmvc = 1'b1;
				r0_pkg::adr_r0_legy: cmd_n.load_legy = 1'b1;
				r0_pkg::adr_r0_x: cmd_n.load_x = 1'b1;
				r0_pkg::adr_r0_user: cmd_n.load_user = 1'b1;
				default: begin
				end
			endcase
			// dat[15] lands in w[0], the Z position
			cmd_n.w = req.dat;
		end

		// Strobe set of the latched opcode
		if (exe_pend) begin
			case (op)
				r0_pkg::op_add, r0_pkg::op_sub: begin
					cmd_n.ust_z = 1'b1;
					cmd_n.ust_mc = 1'b1;
					cmd_n.ust_v = 1'b1;
				end
				r0_pkg::op_and, r0_pkg::op_or, r0_pkg::op_xor: begin
					cmd_n.ust_z = 1'b1;
				end
				r0_pkg::op_cmp: begin
					cmd_n.cleg = 1'b1;
				end
				r0_pkg::op_shl: begin
					cmd_n.ust_z = 1'b1;
					cmd_n.ust_y = 1'b1;
				end
				r0_pkg::op_shr: begin
					cmd_n.ust_z = 1'b1;
					cmd_n.ust_x = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// Commands are one-cycle pulses
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			cmd <= '0;
		end else begin
			cmd <= cmd_n;
		end
	end

	// Read data, captured with ack
	always_ff @(posedge clk0) begin
		if (acc && !req.we) begin
			case (req.adr)
				r0_pkg::adr_a: rd_dat <= a;
				r0_pkg::adr_b: rd_dat <= b;
				r0_pkg::adr_op: rd_dat <= {13'd0, op};
				r0_pkg::adr_res: rd_dat <= res_q;
				// All four R0 addresses return the whole word, Z on dat[15]
				default: rd_dat <= r0;
			endcase
		end
	end

	assign rsp.ack = ack_q;
	assign rsp.dat = rd_dat;

	// Master must see a low ack before the next access
	a_ack_single: assert property (@(posedge clk0) disable iff (!reset4)
		rsp.ack |=> !rsp.ack);

	// No ack without a request the cycle before
	a_ack_cause: assert property (@(posedge clk0) disable iff (!reset4)
		rsp.ack |-> $past(req.cyc && req.stb));

endmodule

// File: rtl/r0_flags.sv
/*
	R0 flag and status register
	Flags captured from the ALU on update strobes, or loaded in groups
	from the bus word; user bits 9 to 15 only load from the bus
*/

`timescale 1ns/1ns

module r0_flags (
	input logic clk0,
	input logic reset4,
	input r0_pkg::r0_cmd_t cmd,
	input r0_pkg::alu_flags_t src,
	output logic [0:15] r0
);

	logic z;
	logic m;
	logic v;
	logic c;
	logic l;
	logic e;
	logic g;
	logic y;
	logic x;
	logic [9:15] usr;

	// Z flag
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			z <= 1'b0;
		end else if (cmd.load_zmvc) begin
			z <= cmd.w[r0_pkg::f_z];
		end else if (cmd.ust_z) begin
			z <= src.zs;
		end
	end

	// M and C share one strobe
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			m <= 1'b0;
			c <= 1'b0;
		end else if (cmd.load_zmvc) begin
			m <= cmd.w[r0_pkg::f_m];
			c <= cmd.w[r0_pkg::f_c];
		end else if (cmd.ust_mc) begin
			m <= src.sign;
			c <= src.carry;
		end
	end

	// V flag
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			v <= 1'b0;
		end else if (cmd.load_zmvc) begin
			v <= cmd.w[r0_pkg::f_v];
		end else if (cmd.ust_v) begin
			v <= src.ovf;
		end
	end

	// L, E, G from a compare
	// Stored true, not inverted
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			l <= 1'b0;
			e <= 1'b0;
			g <= 1'b0;
		end else if (cmd.load_legy) begin
			l <= cmd.w[r0_pkg::f_l];
			e <= cmd.w[r0_pkg::f_e];
			g <= cmd.w[r0_pkg::f_g];
		end else if (cmd.cleg) begin
			l <= src.lt;
			e <= src.eq;
			g <= src.gt;
		end
	end

	// Y flag, loaded with the LEG group
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			y <= 1'b0;
		end else if (cmd.load_legy) begin
			y <= cmd.w[r0_pkg::f_y];
		end else if (cmd.ust_y) begin
			y <= src.shy;
		end
	end

	// X flag has its own load
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			x <= 1'b0;
		end else if (cmd.load_x) begin
			x <= cmd.w[r0_pkg::f_x];
		end else if (cmd.ust_x) begin
			x <= src.shx;
		end
	end

	// User bits
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			usr <= '0;
		end else if (cmd.load_user) begin
			usr <= cmd.w[9:15];
		end
	end

	// Assemble R0 in architectural order
	assign r0[r0_pkg::f_z] = z;
	assign r0[r0_pkg::f_m] = m;
	assign r0[r0_pkg::f_v] = v;
	assign r0[r0_pkg::f_c] = c;
	assign r0[r0_pkg::f_l] = l;
	assign r0[r0_pkg::f_e] = e;
	assign r0[r0_pkg::f_g] = g;
	assign r0[r0_pkg::f_y] = y;
	assign r0[r0_pkg::f_x] = x;
	assign r0[9:15] = usr;

	// Loads come from bus writes and strobes from a finished execute
	// The port keeps them in separate cycles
	a_load_vs_strobe: assert property (@(posedge clk0) disable iff (!reset4)
		(cmd.load_zmvc || cmd.load_legy || cmd.load_x || cmd.load_user) |->
		!(cmd.ust_z || cmd.ust_mc || cmd.ust_v || cmd.ust_y || cmd.ust_x || cmd.cleg));

	// One bus write selects one group
	a_one_load: assert property (@(posedge clk0) disable iff (!reset4)
		$onehot0({cmd.load_zmvc, cmd.load_legy, cmd.load_x, cmd.load_user}));

endmodule

// File: rtl/alu16.sv
/*
	16-bit ALU
	Combinational add, subtract, logic, compare and single-bit shifts,
	with every R0 flag source produced alongside the result
*/

`timescale 1ns/1ns

module alu16 (
	input logic [15:0] a,
	input logic [15:0] b,
	input r0_pkg::alu_op_t op,
	output logic [15:0] res,
	output r0_pkg::alu_flags_t flags
);

	logic sub;
	logic arith;
	logic [15:0] bx;
	logic [16:0] sum_u;
	logic [16:0] sum_s;

	// Subtract is a plus inverted b plus one
	assign sub = (op == r0_pkg::op_sub);
	assign arith = (op == r0_pkg::op_add) || sub;
	assign bx = sub ? ~b : b;

	// Zero-extended sum, bit 16 is the carry
	assign sum_u = {1'b0, a} + {1'b0, bx} + {16'd0, sub};

	// Sign-extended sum, bit 16 is the extra sign bit
	assign sum_s = {a[15], a} + {bx[15], bx} + {16'd0, sub};

	// Result select
	always_comb begin
		case (op)
			r0_pkg::op_add: begin
				res = sum_u[15:0];
			end
			r0_pkg::op_sub: begin
				res = sum_u[15:0];
			end
			r0_pkg::op_and: begin
				res = a & b;
			end
			r0_pkg::op_or: begin
				res = a | b;
			end
			r0_pkg::op_xor: begin
				res = a ^ b;
			end
			// Compare passes a through
			r0_pkg::op_cmp: begin
				res = a;
			end
			r0_pkg::op_shl: begin
				res = {a[14:0], 1'b0};
			end
			// Logical shift, zero enters at the top
			r0_pkg::op_shr: begin
				res = {1'b0, a[15:1]};
			end
			default: begin
				res = a;
			end
		endcase
	end

	// Flag sources
	always_comb begin
		flags = '0;

		// Zero and minus follow the selected result
		flags.zs = (res == 16'd0);
		flags.sign = res[15];

		// Carry and overflow only for add and subtract
		if (arith) begin
			flags.carry = sum_u[16];
			// Extended sign differs from result sign on overflow
			flags.ovf = sum_s[16] ^ sum_s[15];
		end

		// Signed compare, exactly one of the three is set
		if (op == r0_pkg::op_cmp) begin
			flags.lt = ($signed(a) < $signed(b));
			flags.eq = (a == b);
			flags.gt = ($signed(a) > $signed(b));
		end

		// Bits that fall off the shifter
		if (op == r0_pkg::op_shl) begin
			flags.shy = a[15];
		end
		if (op == r0_pkg::op_shr) begin
			flags.shx = a[0];
		end
	end

endmodule

// File: rtl/r0_pkg.sv
/*
	R0 flag subsystem shared definitions
	Wishbone request and response structs, ALU opcodes and flag sources,
	R0 commands, flag bit positions and the port register map
*/

package r0_pkg;

	// Master to slave, held by the master until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [2:0] adr;
		logic [15:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// ALU operations, op_add is the reset value of the latched opcode
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_cmp = 3'd5,
		op_shl = 3'd6,
		op_shr = 3'd7
	} alu_op_t;

	// Flag sources, valid combinationally for the current operands and opcode
	typedef struct packed {
		logic zs;
		logic sign;
		logic ovf;
		logic carry;
		logic lt;
		logic eq;
		logic gt;
		logic shy;
		logic shx;
	} alu_flags_t;

	// One-cycle commands to R0
	typedef struct packed {
		logic load_zmvc;
		logic load_legy;
		logic load_x;
		logic load_user;
		logic ust_z;
		logic ust_mc;
		logic ust_v;
		logic ust_y;
		logic ust_x;
		logic cleg;
		// Bus word, bit 0 is the MSB as in R0
		logic [0:15] w;
	} r0_cmd_t;

	// Flag positions in R0, bit 0 is the MSB
	localparam int f_z = 0;
	localparam int f_m = 1;
	localparam int f_v = 2;
	localparam int f_c = 3;
	localparam int f_l = 4;
	localparam int f_e = 5;
	localparam int f_g = 6;
	localparam int f_y = 7;
	localparam int f_x = 8;

	// Word addresses of the slave port
	localparam logic [2:0] adr_a       = 3'd0;
	localparam logic [2:0] adr_b       = 3'd1;
	localparam logic [2:0] adr_op      = 3'd2;
	localparam logic [2:0] adr_res     = 3'd3;
	localparam logic [2:0] adr_r0_zmvc = 3'd4;
	localparam logic [2:0] adr_r0_legy = 3'd5;
	localparam logic [2:0] adr_r0_x    = 3'd6;
	localparam logic [2:0] adr_r0_user = 3'd7;

endpackage
